/* alu_cfg.svh */
/*
 * Configuration macros for the execution stage
 * Operand width, register address width and pipeline depth
 */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width in bits
`define ALU_DATA_WIDTH 32

// Width of the destination register address
`define ALU_ADDR_WIDTH 8

// Clock edges from acceptance of an instruction to its result,
// identical for every lane
`define ALU_PIPELINE_DEPTH 5

`endif

/* alu_pkg.sv */
/*
 * Shared types of the execution stage
 * Opcode enum, issue and result structs, per-lane carrier
 */
`include "alu_cfg.svh"

package alu_pkg;

    // Encodings follow the core's instruction set, gaps are the float ops
    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        MUL  = 5'd3,
        LDC  = 5'd6,
        LDR  = 5'd7,
        BGT  = 5'd8,
        BLE  = 5'd9,
        BEQ  = 5'd10,
        BNE  = 5'd11,
        STOP = 5'd12,
        AND  = 5'd13,
        OR   = 5'd14,
        NOT  = 5'd15,
        SATP = 5'd16,
        SATN = 5'd17
    } opcode_e;

    // One instruction as handed over by the core
    typedef struct packed {
        opcode_e                    op;
        logic [`ALU_DATA_WIDTH-1:0] a;
        logic [`ALU_DATA_WIDTH-1:0] b;
        logic [`ALU_ADDR_WIDTH-1:0] dest;
    } issue_t;

    // Write-back value and its target register
    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] data;
        logic [`ALU_ADDR_WIDTH-1:0] dest;
    } result_t;

    // What each lane carries down the pipeline
    typedef struct packed {
        logic    valid;
        result_t res;
    } lane_t;

endpackage

/* add_unit.sv */
/*
 * Adder/subtractor lane, two register stages
 * Handles ADD and SUB with wrap-around modulo 2^32
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module add_unit (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             issue_fire,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::lane_t   lane
);

    logic                       is_sub;
    logic                       s1_valid;
    logic [`ALU_DATA_WIDTH-1:0] s1_a;
    logic [`ALU_DATA_WIDTH-1:0] s1_b;
    logic                       s1_cin;
    logic [`ALU_ADDR_WIDTH-1:0] s1_dest;
    logic                       s2_valid;
    alu_pkg::result_t           s2_res;

    assign is_sub = (issue.op == alu_pkg::SUB);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= issue_fire && (issue.op == alu_pkg::ADD || is_sub);
            s2_valid <= s1_valid;
        end
    end

    // Subtraction as a + ~b + 1
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_a        <= issue.a;
            s1_b        <= is_sub ? ~issue.b : issue.b;
            s1_cin      <= is_sub;
            s1_dest     <= issue.dest;
            s2_res.data <= s1_a + s1_b + `ALU_DATA_WIDTH'(s1_cin);
            s2_res.dest <= s1_dest;
        end
    end

    assign lane.valid = s2_valid;
    assign lane.res   = s2_res;

endmodule

/* mul_unit.sv */
/*
 * Multiplier lane, three register stages
 * Signed product, low half returned
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module mul_unit (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             issue_fire,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::lane_t   lane
);

    logic                                s1_valid;
    logic signed [`ALU_DATA_WIDTH-1:0]   s1_a;
    logic signed [`ALU_DATA_WIDTH-1:0]   s1_b;
    logic        [`ALU_ADDR_WIDTH-1:0]   s1_dest;
    logic                                s2_valid;
    logic signed [2*`ALU_DATA_WIDTH-1:0] s2_prod;
    logic        [`ALU_ADDR_WIDTH-1:0]   s2_dest;
    logic                                s3_valid;
    alu_pkg::result_t                    s3_res;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= issue_fire && (issue.op == alu_pkg::MUL);
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // Operands are registered before the multiplier so the product
    // gets a full cycle of its own
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_a        <= issue.a;
            s1_b        <= issue.b;
            s1_dest     <= issue.dest;
            s2_prod     <= s1_a * s1_b;
            s2_dest     <= s1_dest;
            s3_res.data <= s2_prod[`ALU_DATA_WIDTH-1:0];
            s3_res.dest <= s2_dest;
        end
    end

    assign lane.valid = s3_valid;
    assign lane.res   = s3_res;

endmodule

/* compare_unit.sv */
/*
 * Branch-condition lane, one register stage
 * Signed BGT, BLE, BEQ and BNE giving 1 or 0
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module compare_unit (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             issue_fire,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::lane_t   lane
);

    logic             claim;
    logic             cond;
    logic             out_valid;
    alu_pkg::result_t out_res;

    always_comb begin
        claim = 1'b1;
        cond  = 1'b0;
        case (issue.op)
            alu_pkg::BGT: cond = $signed(issue.a) > $signed(issue.b);
            alu_pkg::BLE: cond = $signed(issue.a) <= $signed(issue.b);
            alu_pkg::BEQ: cond = (issue.a == issue.b);
            alu_pkg::BNE: cond = (issue.a != issue.b);
            default:      claim = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= issue_fire && claim;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_res.data <= {{(`ALU_DATA_WIDTH-1){1'b0}}, cond};
            out_res.dest <= issue.dest;
        end
    end

    assign lane.valid = out_valid;
    assign lane.res   = out_res;

endmodule

/* logic_sat_unit.sv */
/*
 * Logic and saturation lane, one register stage
 * AND, OR, NOT, and signed clipping against the limit in b
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module logic_sat_unit (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             issue_fire,
    input  alu_pkg::issue_t  issue,
    output alu_pkg::lane_t   lane
);

    logic                       claim;
    logic                       a_above_b;
    logic [`ALU_DATA_WIDTH-1:0] next_data;
    logic                       out_valid;
    alu_pkg::result_t           out_res;

    // One signed comparator serves both clipping directions
    assign a_above_b = $signed(issue.a) > $signed(issue.b);

    always_comb begin
        claim     = 1'b1;
        next_data = '0;
        case (issue.op)
            alu_pkg::AND: next_data = issue.a & issue.b;
            alu_pkg::OR:  next_data = issue.a | issue.b;
            alu_pkg::NOT: next_data = ~issue.a;
            // Upper limit, a is pulled down to b
            alu_pkg::SATP: begin
                next_data = a_above_b ? issue.b : issue.a;
            end
            // Lower limit, a is pulled up to b
            alu_pkg::SATN: begin
                next_data = a_above_b ? issue.a : issue.b;
            end
            default: claim = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= issue_fire && claim;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_res.data <= next_data;
            out_res.dest <= issue.dest;
        end
    end

    assign lane.valid = out_valid;
    assign lane.res   = out_res;

endmodule

/* delay_line.sv */
/*
 * Stall-aware chain of lane registers
 * Pads a lane so all lanes share one pipeline depth
 */
`timescale 1ns/100ps

module delay_line #(
    parameter int STAGES = 1
) (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           advance,
    input  alu_pkg::lane_t lane_in,
    output alu_pkg::lane_t lane_out
);

    logic             valid_q [STAGES];
    alu_pkg::result_t res_q   [STAGES];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (advance) begin
            valid_q[0] <= lane_in.valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // The data shifts with the valid bit, nothing moves during a stall
    always_ff @(posedge clock) begin
        if (advance) begin
            res_q[0] <= lane_in.res;
            for (int i = 1; i < STAGES; i++) begin
                res_q[i] <= res_q[i-1];
            end
        end
    end

    assign lane_out.valid = valid_q[STAGES-1];
    assign lane_out.res   = res_q[STAGES-1];

endmodule

/* exec_alu.sv */
/*
 * Execution stage top level
 * Issue and result handshakes, functional lanes, load path,
 * padding to a fixed depth and the one-hot result mux
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module exec_alu (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  alu_pkg::issue_t    issue,
    output logic               result_valid,
    input  logic               result_ready,
    output alu_pkg::result_t   result
);

    localparam int N_LANES   = 5;
    localparam int LANE_ADD  = 0;
    localparam int LANE_MUL  = 1;
    localparam int LANE_CMP  = 2;
    localparam int LANE_LOG  = 3;
    localparam int LANE_LOAD = 4;

    // Register stages inside each lane, in lane index order
    localparam int LANE_LATENCY [N_LANES] = '{2, 3, 1, 1, 0};

    logic           advance;
    logic           issue_fire;
    alu_pkg::lane_t lane_raw [N_LANES];
    alu_pkg::lane_t lane_pad [N_LANES];

    // The whole pipeline moves as one unless the output is blocked
    assign advance     = result_ready || !result_valid;
    assign issue_ready = advance;
    assign issue_fire  = issue_valid && advance;

    add_unit u_add_unit (
        .clock      (clock),
        .arst_n     (arst_n),
        .advance    (advance),
        .issue_fire (issue_fire),
        .issue      (issue),
        .lane       (lane_raw[LANE_ADD])
    );

    mul_unit u_mul_unit (
        .clock      (clock),
        .arst_n     (arst_n),
        .advance    (advance),
        .issue_fire (issue_fire),
        .issue      (issue),
        .lane       (lane_raw[LANE_MUL])
    );

    compare_unit u_compare_unit (
        .clock      (clock),
        .arst_n     (arst_n),
        .advance    (advance),
        .issue_fire (issue_fire),
        .issue      (issue),
        .lane       (lane_raw[LANE_CMP])
    );

    logic_sat_unit u_logic_sat_unit (
        .clock      (clock),
        .arst_n     (arst_n),
        .advance    (advance),
        .issue_fire (issue_fire),
        .issue      (issue),
        .lane       (lane_raw[LANE_LOG])
    );

    // Load path has no stages of its own, LDC takes the immediate from b
    always_comb begin
        lane_raw[LANE_LOAD].valid    = issue_fire &&
                                       (issue.op == alu_pkg::LDR ||
                                        issue.op == alu_pkg::LDC);
        lane_raw[LANE_LOAD].res.data = (issue.op == alu_pkg::LDC) ? issue.b : issue.a;
        lane_raw[LANE_LOAD].res.dest = issue.dest;
    end

    for (genvar g = 0; g < N_LANES; g++) begin : g_pad
        delay_line #(
            .STAGES (`ALU_PIPELINE_DEPTH - LANE_LATENCY[g])
        ) u_delay_line (
            .clock    (clock),
            .arst_n   (arst_n),
            .advance  (advance),
            .lane_in  (lane_raw[g]),
            .lane_out (lane_pad[g])
        );
    end

    // Only one instruction sits at the last depth, so at most one
    // lane is valid here and a plain OR of masked values is enough
    always_comb begin
        result_valid = 1'b0;
        result       = '0;
        for (int i = 0; i < N_LANES; i++) begin
            result_valid = result_valid | lane_pad[i].valid;
            if (lane_pad[i].valid) begin
                result = result | lane_pad[i].res;
            end
        end
    end

endmodule

/* alu_tb.sv */
/*
 * Directed testbench for the execution stage
 * Clock, reset, LCG, reference model, compare tasks, test tasks, watchdog
 */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_tb;

    localparam logic [31:0] SEED = 32'h988f_b4bc;
    localparam int TOTAL_ISSUED  = 12 + 10 + 16 + 15 + 8 + 40;

    logic             clock;
    logic             arst_n;
    logic             issue_valid;
    logic             issue_ready;
    alu_pkg::issue_t  issue;
    logic             result_valid;
    logic             result_ready;
    alu_pkg::result_t result;

    alu_pkg::result_t expected_q [$];
    int               accept_q   [$];
    logic [31:0]      rnd_state   = SEED;
    logic [31:0]      ready_state = SEED;
    int               cycle       = 0;
    int               errors      = 0;
    int               test_start_errors;
    int               claimed_count;
    int               received_count;
    int               ok_tests    = 0;
    int               failing_tests = 0;
    bit               ready_toggle  = 1'b0;
    bit               latency_check = 1'b0;
    string            current_test  = "reset";

    alu_pkg::opcode_e all_ops [16] = '{
        alu_pkg::NOP, alu_pkg::ADD, alu_pkg::SUB, alu_pkg::MUL,
        alu_pkg::LDC, alu_pkg::LDR, alu_pkg::BGT, alu_pkg::BLE,
        alu_pkg::BEQ, alu_pkg::BNE, alu_pkg::STOP, alu_pkg::AND,
        alu_pkg::OR, alu_pkg::NOT, alu_pkg::SATP, alu_pkg::SATN
    };

    exec_alu u_exec_alu (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_random();
        rnd_state = lcg_step(rnd_state);
        return rnd_state;
    endfunction

    // Reference behavior of every opcode
    function automatic alu_pkg::result_t model(input alu_pkg::issue_t ins);
        alu_pkg::result_t  r;
        logic signed [63:0] prod;
        r.dest = ins.dest;
        r.data = '0;
        prod   = $signed(ins.a) * $signed(ins.b);
        case (ins.op)
            alu_pkg::ADD:  r.data = ins.a + ins.b;
            alu_pkg::SUB:  r.data = ins.a - ins.b;
            alu_pkg::MUL:  r.data = prod[31:0];
            alu_pkg::LDC:  r.data = ins.b;
            alu_pkg::LDR:  r.data = ins.a;
            alu_pkg::BGT:  r.data = 32'($signed(ins.a) > $signed(ins.b));
            alu_pkg::BLE:  r.data = 32'($signed(ins.a) <= $signed(ins.b));
            alu_pkg::BEQ:  r.data = 32'(ins.a == ins.b);
            alu_pkg::BNE:  r.data = 32'(ins.a != ins.b);
            alu_pkg::AND:  r.data = ins.a & ins.b;
            alu_pkg::OR:   r.data = ins.a | ins.b;
            alu_pkg::NOT:  r.data = ~ins.a;
            alu_pkg::SATP: r.data = ($signed(ins.a) < $signed(ins.b)) ? ins.a : ins.b;
            alu_pkg::SATN: r.data = ($signed(ins.a) > $signed(ins.b)) ? ins.a : ins.b;
            default:       r.data = '0;
        endcase
        return r;
    endfunction

    function automatic bit claims(input alu_pkg::opcode_e op);
        return !(op == alu_pkg::NOP || op == alu_pkg::STOP);
    endfunction

    task automatic check_result(input string name, input alu_pkg::result_t exp,
                                input alu_pkg::result_t act);
        if (exp !== act) begin
            $display("** Error %s: expected data %h dest %h, actual data %h dest %h",
                     name, exp.data, exp.dest, act.data, act.dest);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Result ready is either held high or follows its own LCG stream
    always @(posedge clock) begin
        if (ready_toggle) begin
            ready_state = lcg_step(ready_state);
            result_ready <= ready_state[30];
        end else begin
            result_ready <= 1'b1;
        end
    end

    always @(posedge clock) begin : collect_results
        alu_pkg::result_t exp_res;
        int               acc_cycle;
        if (arst_n) begin
            // The core may only issue while the output is not blocked
            check_count({current_test, " issue_ready"},
                        int'(result_ready || !result_valid), int'(issue_ready));
            if (result_valid && result_ready) begin
                received_count++;
                if (expected_q.size() == 0) begin
                    $display("%s: a result arrived with no instruction outstanding",
                             current_test);
                    errors++;
                end else begin
                    exp_res   = expected_q.pop_front();
                    acc_cycle = accept_q.pop_front();
                    check_result(current_test, exp_res, result);
                    if (latency_check) begin
                        check_count({current_test, " latency"},
                                    `ALU_PIPELINE_DEPTH, cycle - acc_cycle);
                    end
                end
            end
        end
    end

    task automatic issue_one(input alu_pkg::opcode_e op, input logic [31:0] a,
                             input logic [31:0] b);
        alu_pkg::issue_t ins;
        logic [31:0]     r;
        r        = next_random();
        ins.op   = op;
        ins.a    = a;
        ins.b    = b;
        ins.dest = r[31:24];
        issue_valid <= 1'b1;
        issue       <= ins;
        @(posedge clock);
        while (!issue_ready) begin
            @(posedge clock);
        end
        if (claims(op)) begin
            expected_q.push_back(model(ins));
            accept_q.push_back(cycle);
            claimed_count++;
        end
    endtask

    task automatic begin_test(input string name, input bit latency_on, input bit toggle_on);
        current_test      = name;
        test_start_errors = errors;
        claimed_count     = 0;
        received_count    = 0;
        latency_check     = latency_on;
        ready_toggle     <= toggle_on;
    endtask

    // Drain the pipeline, then allow time for any stray result to show up
    task automatic end_test();
        int n_err;
        issue_valid <= 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
        ready_toggle <= 1'b0;
        repeat (`ALU_PIPELINE_DEPTH + 3) @(posedge clock);
        check_count({current_test, " count"}, claimed_count, received_count);
        n_err = errors - test_start_errors;
        if (n_err == 0) begin
            ok_tests++;
        end else begin
            failing_tests++;
        end
        $display("%-18s %0d results, %0d errors", current_test, received_count, n_err);
    endtask

    task automatic wrap_add_sub();
        logic [31:0] r;
        begin_test("add_sub", 1'b1, 1'b0);
        issue_one(alu_pkg::ADD, 32'h7fff_ffff, 32'd1);
        issue_one(alu_pkg::SUB, 32'h8000_0000, 32'd1);
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            if (r[20]) begin
                issue_one(alu_pkg::SUB, next_random(), next_random());
            end else begin
                issue_one(alu_pkg::ADD, next_random(), next_random());
            end
        end
        end_test();
    endtask

    task automatic multiply_signed();
        begin_test("mul", 1'b0, 1'b0);
        issue_one(alu_pkg::MUL, -32'sd7, -32'sd9);
        issue_one(alu_pkg::MUL, 32'h7fff_ffff, 32'h7fff_ffff);
        issue_one(alu_pkg::MUL, -32'sd123456, 32'sd789);
        for (int i = 0; i < 7; i++) begin
            issue_one(alu_pkg::MUL, next_random(), next_random());
        end
        end_test();
    endtask

    task automatic compare_branches();
        alu_pkg::opcode_e cmp_ops [4];
        logic [31:0]      r;
        cmp_ops[0] = alu_pkg::BGT;
        cmp_ops[1] = alu_pkg::BLE;
        cmp_ops[2] = alu_pkg::BEQ;
        cmp_ops[3] = alu_pkg::BNE;
        begin_test("compare", 1'b0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            r = next_random();
            issue_one(cmp_ops[k], 32'd5, 32'd5);
            issue_one(cmp_ops[k], 32'd7, -32'sd3);
            issue_one(cmp_ops[k], -32'sd3, 32'd7);
            issue_one(cmp_ops[k], r, next_random());
        end
        end_test();
    endtask

    task automatic logic_and_clip();
        begin_test("logic_sat", 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            issue_one(alu_pkg::AND, next_random(), next_random());
            issue_one(alu_pkg::OR, next_random(), next_random());
            issue_one(alu_pkg::NOT, next_random(), next_random());
        end
        // Limit of 100 with a below, at and above it
        issue_one(alu_pkg::SATP, -32'sd50, 32'd100);
        issue_one(alu_pkg::SATP, 32'd100, 32'd100);
        issue_one(alu_pkg::SATP, 32'd250, 32'd100);
        issue_one(alu_pkg::SATN, -32'sd50, -32'sd20);
        issue_one(alu_pkg::SATN, -32'sd20, -32'sd20);
        issue_one(alu_pkg::SATN, 32'd250, -32'sd20);
        end_test();
    endtask

    task automatic load_and_skip();
        begin_test("load_nop", 1'b0, 1'b0);
        issue_one(alu_pkg::LDR, next_random(), next_random());
        issue_one(alu_pkg::LDC, next_random(), next_random());
        issue_one(alu_pkg::NOP, next_random(), next_random());
        issue_one(alu_pkg::STOP, next_random(), next_random());
        issue_one(alu_pkg::LDR, next_random(), next_random());
        issue_one(alu_pkg::NOP, next_random(), next_random());
        issue_one(alu_pkg::LDC, next_random(), next_random());
        issue_one(alu_pkg::STOP, next_random(), next_random());
        end_test();
    endtask

    task automatic stream_mixed_ops();
        logic [31:0] r;
        begin_test("mixed_stream", 1'b0, 1'b1);
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            issue_one(all_ops[r[27:24]], next_random(), next_random());
        end
        end_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        result_ready = 1'b1;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        wrap_add_sub();
        multiply_signed();
        compare_branches();
        logic_and_clip();
        load_and_skip();
        stream_mixed_ops();
        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 ok_tests, failing_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Generous bound of 20 cycles per issued instruction
    initial begin
        repeat (TOTAL_ISSUED * 20 + 200) @(posedge clock);
        $display("Timeout in %s: results stopped arriving before all tests finished",
                 current_test);
        $display("Test failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
alu_pkg.sv
add_unit.sv
mul_unit.sv
compare_unit.sv
logic_sat_unit.sv
delay_line.sv
exec_alu.sv
alu_tb.sv
